// ==== hw/rv_decode_pkg.sv ====
// RV32I decode stage package: widths, encodings, enums and the decoded bundle
`default_nettype none

package rv_decode_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    localparam int XLEN        = 32;
    localparam int INS_W       = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int CSR_ADDR_W  = 12;
    localparam int DEC_CREDITS = 2;  // bundles execute can buffer
    localparam int CREDIT_W    = $clog2(DEC_CREDITS + 1);

    // ------------------------------------------------------------------------
    // encodings
    // ------------------------------------------------------------------------
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

    localparam logic [2:0] F3_ADDSUB = 3'b000;
    localparam logic [2:0] F3_SLL    = 3'b001;
    localparam logic [2:0] F3_SLT    = 3'b010;
    localparam logic [2:0] F3_SLTU   = 3'b011;
    localparam logic [2:0] F3_XOR    = 3'b100;
    localparam logic [2:0] F3_SRLSRA = 3'b101;
    localparam logic [2:0] F3_OR     = 3'b110;
    localparam logic [2:0] F3_AND    = 3'b111;
    localparam logic [2:0] F3_PRIV   = 3'b000;
    localparam logic [2:0] F3_FENCEI = 3'b001;

    localparam logic [6:0] F7_BASE       = 7'b0000000;
    localparam logic [6:0] F7_ALT        = 7'b0100000;
    localparam logic [6:0] F7_SFENCE_VMA = 7'b0001001;

    // funct12 of privileged ops
    localparam logic [11:0] F12_ECALL  = 12'h000;
    localparam logic [11:0] F12_EBREAK = 12'h001;
    localparam logic [11:0] F12_WFI    = 12'h105;
    localparam logic [7:0]  F8_TRAP_RTN = 8'h02;  // bits 27:20, mode in 29:28

    // ------------------------------------------------------------------------
    // types
    // ------------------------------------------------------------------------
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_MOV
    } alu_op_e;

    typedef enum logic [1:0] {
        ZONE_NONE, ZONE_REGFILE, ZONE_LOADQ, ZONE_STOREQ
    } zone_e;

    typedef enum logic [2:0] {
        IMM_R, IMM_I, IMM_I_ZIMM, IMM_S, IMM_SB, IMM_U, IMM_UJ, IMM_MISC_MEM
    } imm_type_e;

    typedef struct packed {
        logic                  err;
        logic                  fencei;
        logic                  wfi;
        logic                  jump;
        logic                  ecall;
        logic                  trap_rtn;
        logic [1:0]            trap_rtn_mode;
        zone_e                 zone;
        logic                  regd_tgt;
        logic [REG_ADDR_W-1:0] regd_addr;
        logic                  regs1_rd;
        logic [REG_ADDR_W-1:0] regs1_addr;
        logic                  regs2_rd;
        logic [REG_ADDR_W-1:0] regs2_addr;
        logic [XLEN-1:0]       imm;
        logic                  link;
        logic                  sels1_pc;
        logic                  sels2_imm;
        logic                  selcmps2_imm;
        logic                  sel_csr_wr_data_imm;
        alu_op_e               aluop;
        logic [2:0]            funct3;
        logic                  csr_rd;
        logic                  csr_wr;
        logic [CSR_ADDR_W-1:0] csr_addr;
        logic                  conditional;
    } dec_bundle_t;

endpackage

`default_nettype wire

// ==== hw/rv_alu_op_decode.sv ====
// funct3/funct7 decode of the op and op-imm groups into an ALU opcode
`timescale 1ns/1ps
`default_nettype none

module rv_alu_op_decode import rv_decode_pkg::*; (
    input  logic [INS_W-1:0] ins_i,
    input  logic             imm_form_i,
    output alu_op_e          alu_op_o,
    output logic             cmp_imm_o,
    output logic             err_o
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_alt;
    logic       alt_ok;

    assign funct3 = ins_i[14:12];
    assign funct7 = ins_i[31:25];
    assign is_alt = (funct7 == F7_ALT);
    // only add/sub (register form) and the right shifts take the alternate funct7
    assign alt_ok = (funct3 == F3_SRLSRA) || (funct3 == F3_ADDSUB && !imm_form_i);

    always_comb begin
        cmp_imm_o = 1'b0;
        case (funct3)
            F3_ADDSUB: alu_op_o = (alt_ok && is_alt) ? ALU_SUB : ALU_ADD;
            F3_SLL:    alu_op_o = ALU_SLL;
            F3_SLT: begin
                alu_op_o  = ALU_SLT;
                cmp_imm_o = imm_form_i;
            end
            F3_SLTU: begin
                alu_op_o  = ALU_SLTU;
                cmp_imm_o = imm_form_i;
            end
            F3_XOR:    alu_op_o = ALU_XOR;
            F3_SRLSRA: alu_op_o = is_alt ? ALU_SRA : ALU_SRL;
            F3_OR:     alu_op_o = ALU_OR;
            default:   alu_op_o = ALU_AND;
        endcase
    end

    // funct7 legality
    always_comb begin
        err_o = 1'b0;
        if (imm_form_i) begin
            if (funct3 == F3_SLL) begin
                err_o = (funct7 != F7_BASE);
            end else if (funct3 == F3_SRLSRA) begin
                err_o = (funct7 != F7_BASE) && !is_alt;
            end
        end else begin
            err_o = !((funct7 == F7_BASE) || (is_alt && alt_ok));
        end
    end

endmodule

`default_nettype wire

// ==== hw/rv_sys_decode.sv ====
// system opcode decode: privileged instructions and CSR access
`timescale 1ns/1ps
`default_nettype none

module rv_sys_decode import rv_decode_pkg::*; (
    input  logic [INS_W-1:0] ins_i,
    output dec_bundle_t      sys_o,  // system and csr fields only
    output logic             err_o
);

    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] funct12;
    logic        rd_zero;
    logic        rs1_zero;

    assign funct3   = ins_i[14:12];
    assign funct7   = ins_i[31:25];
    assign funct12  = ins_i[31:20];
    assign rd_zero  = (ins_i[11:7] == '0);
    assign rs1_zero = (ins_i[19:15] == '0);

    always_comb begin
        sys_o               = '0;
        err_o               = 1'b0;
        sys_o.trap_rtn_mode = ins_i[29:28];
        sys_o.csr_addr      = funct12;

        if (funct3 == F3_PRIV) begin
            if (!rd_zero || funct7 == F7_SFENCE_VMA || !rs1_zero) begin
                err_o = 1'b1;
            end else if (funct12 == F12_ECALL) begin
                sys_o.ecall = 1'b1;
            end else if (funct12 == F12_EBREAK) begin
                err_o = 1'b0;  // ebreak, no action
            end else if (ins_i[31:30] == 2'b00 && ins_i[27:20] == F8_TRAP_RTN) begin
                sys_o.trap_rtn = 1'b1;
            end else if (funct12 == F12_WFI) begin
                sys_o.wfi = 1'b1;
            end else begin
                err_o = 1'b1;
            end
        end else if (funct3[1:0] != 2'b00) begin
            // csrrw/s/c, zimm variants have funct3[2] set
            sys_o.csr_rd              = !rd_zero;
            sys_o.csr_wr              = !rs1_zero;
            sys_o.sel_csr_wr_data_imm = funct3[2];
        end else begin
            err_o = 1'b1;  // funct3 100 is reserved
        end
    end

endmodule

`default_nettype wire

// ==== hw/rv_imm_gen.sv ====
// immediate extraction and sign extension per instruction format
`timescale 1ns/1ps
`default_nettype none

module rv_imm_gen import rv_decode_pkg::*; (
    input  logic [INS_W-1:0] ins_i,
    input  imm_type_e        imm_type_i,
    output logic [XLEN-1:0]  imm_o
);

    logic [XLEN-1:0] sign;

    assign sign = {XLEN{ins_i[31]}};

    always_comb begin
        case (imm_type_i)
            IMM_I:      imm_o = {sign[XLEN-1:11], ins_i[30:20]};
            IMM_I_ZIMM: imm_o = {{(XLEN-5){1'b0}}, ins_i[19:15]};
            IMM_S:      imm_o = {sign[XLEN-1:11], ins_i[30:25], ins_i[11:7]};
            IMM_SB: begin
                imm_o = {sign[XLEN-1:12], ins_i[7], ins_i[30:25], ins_i[11:8], 1'b0};
            end
            IMM_U:      imm_o = {ins_i[31:12], 12'b0};
            IMM_UJ: begin
                imm_o = {sign[XLEN-1:20], ins_i[19:12], ins_i[20], ins_i[30:21], 1'b0};
            end
            default:    imm_o = '0;  // r-type, misc-mem
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/rv_ctrl_decode.sv ====
// major-opcode decoder producing the control part of the decoded bundle
`timescale 1ns/1ps
`default_nettype none

module rv_ctrl_decode import rv_decode_pkg::*; (
    input  logic [INS_W-1:0] ins_i,
    output imm_type_e        imm_type_o,
    output dec_bundle_t      ctrl_o      // imm left zero
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic        alu_imm_form;
    alu_op_e     alu_op;
    logic        alu_cmp_imm;
    logic        alu_err;
    dec_bundle_t sys;
    logic        sys_err;

    assign opcode       = ins_i[6:0];
    assign funct3       = ins_i[14:12];
    assign alu_imm_form = (opcode == OPC_OP_IMM);

    rv_alu_op_decode u_alu_op_decode (
        .ins_i      (ins_i),
        .imm_form_i (alu_imm_form),
        .alu_op_o   (alu_op),
        .cmp_imm_o  (alu_cmp_imm),
        .err_o      (alu_err)
    );

    rv_sys_decode u_sys_decode (
        .ins_i (ins_i),
        .sys_o (sys),
        .err_o (sys_err)
    );

    // ------------------------------------------------------------------------
    // opcode decode
    // ------------------------------------------------------------------------
    always_comb begin
        ctrl_o               = '0;
        imm_type_o           = IMM_R;
        ctrl_o.regd_addr     = ins_i[11:7];
        ctrl_o.regs1_addr    = ins_i[19:15];
        ctrl_o.regs2_addr    = ins_i[24:20];
        ctrl_o.funct3        = funct3;
        ctrl_o.trap_rtn_mode = sys.trap_rtn_mode;
        ctrl_o.csr_addr      = sys.csr_addr;
        ctrl_o.aluop         = ALU_ADD;

        case (opcode)
            OPC_LUI, OPC_AUIPC: begin
                imm_type_o       = IMM_U;
                ctrl_o.zone      = ZONE_REGFILE;
                ctrl_o.regd_tgt  = 1'b1;
                ctrl_o.sels2_imm = 1'b1;
                if (opcode == OPC_LUI) begin
                    ctrl_o.aluop = ALU_MOV;
                end else begin
                    ctrl_o.sels1_pc = 1'b1; // pc + imm
                end
            end
            OPC_JAL, OPC_JALR: begin
                ctrl_o.jump      = 1'b1;
                ctrl_o.zone      = ZONE_REGFILE;
                ctrl_o.regd_tgt  = 1'b1;
                ctrl_o.link      = 1'b1;
                ctrl_o.sels2_imm = 1'b1;
                if (opcode == OPC_JAL) begin
                    imm_type_o      = IMM_UJ;
                    ctrl_o.sels1_pc = 1'b1;
                end else begin
                    imm_type_o      = IMM_I;
                    ctrl_o.regs1_rd = 1'b1;
                    ctrl_o.err      = (funct3 != 3'b000);
                end
            end
            OPC_BRANCH: begin
                imm_type_o         = IMM_SB;
                ctrl_o.jump        = 1'b1;
                ctrl_o.conditional = 1'b1;
                ctrl_o.regs1_rd    = 1'b1;
                ctrl_o.regs2_rd    = 1'b1;
                ctrl_o.sels1_pc    = 1'b1;
                ctrl_o.sels2_imm   = 1'b1;
                ctrl_o.err         = (funct3 == 3'b010) || (funct3 == 3'b011);
            end
            OPC_LOAD: begin
                imm_type_o       = IMM_I;
                ctrl_o.zone      = ZONE_LOADQ;
                ctrl_o.regd_tgt  = 1'b1;
                ctrl_o.regs1_rd  = 1'b1;
                ctrl_o.sels2_imm = 1'b1;
                ctrl_o.err       = (funct3 == 3'b011) || (funct3 > 3'b101); // lb..lhu only
            end
            OPC_STORE: begin
                imm_type_o       = IMM_S;
                ctrl_o.zone      = ZONE_STOREQ;
                ctrl_o.regs1_rd  = 1'b1;
                ctrl_o.regs2_rd  = 1'b1;
                ctrl_o.sels2_imm = 1'b1;
                ctrl_o.err       = (funct3 > 3'b010);
            end
            OPC_OP_IMM, OPC_OP: begin
                imm_type_o          = alu_imm_form ? IMM_I : IMM_R;
                ctrl_o.zone         = ZONE_REGFILE;
                ctrl_o.regd_tgt     = 1'b1;
                ctrl_o.regs1_rd     = 1'b1;
                ctrl_o.regs2_rd     = !alu_imm_form;
                ctrl_o.sels2_imm    = alu_imm_form;
                ctrl_o.aluop        = alu_op;
                ctrl_o.selcmps2_imm = alu_cmp_imm;
                ctrl_o.err          = alu_err;
            end
            OPC_MISC_MEM: begin
                imm_type_o    = IMM_MISC_MEM;
                ctrl_o.fencei = (funct3 == F3_FENCEI); // plain fence is a no-op
            end
            OPC_SYSTEM: begin
                ctrl_o.err                 = sys_err;
                ctrl_o.ecall               = sys.ecall;
                ctrl_o.wfi                 = sys.wfi;
                ctrl_o.trap_rtn            = sys.trap_rtn;
                ctrl_o.csr_rd              = sys.csr_rd;
                ctrl_o.csr_wr              = sys.csr_wr;
                ctrl_o.sel_csr_wr_data_imm = sys.sel_csr_wr_data_imm;
                if (funct3[1:0] != 2'b00) begin // csr access
                    ctrl_o.zone     = ZONE_REGFILE;
                    ctrl_o.regd_tgt = 1'b1;
                    ctrl_o.regs1_rd = !funct3[2];
                    if (funct3[2]) begin
                        imm_type_o = IMM_I_ZIMM;
                    end
                end
            end
            default: begin
                ctrl_o.err = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/rv_decode_stage.sv ====
// registered RV32I decode stage with credit-based flow toward execute
`timescale 1ns/1ps
`default_nettype none

module rv_decode_stage import rv_decode_pkg::*; (
    input  logic             clk_i,
    input  logic             arst_n_i,
    // fetch side
    input  logic             ins_valid_i,
    input  logic [INS_W-1:0] ins_i,
    output logic             ins_ready_o,
    // execute side
    output logic             dec_valid_o,
    output dec_bundle_t      dec_o,
    input  logic             credit_i
);

    logic [CREDIT_W-1:0] credits_q;
    logic                accept;
    imm_type_e           imm_type;
    logic [XLEN-1:0]     imm;
    dec_bundle_t         ctrl;
    dec_bundle_t         dec_d;

    rv_ctrl_decode u_ctrl_decode (
        .ins_i      (ins_i),
        .imm_type_o (imm_type),
        .ctrl_o     (ctrl)
    );

    rv_imm_gen u_imm_gen (
        .ins_i      (ins_i),
        .imm_type_i (imm_type),
        .imm_o      (imm)
    );

    always_comb begin
        dec_d     = ctrl;
        dec_d.imm = imm;
    end

    // ------------------------------------------------------------------------
    // credits
    // ------------------------------------------------------------------------
    assign ins_ready_o = (credits_q != '0);
    assign accept      = ins_valid_i && ins_ready_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            credits_q <= CREDIT_W'(DEC_CREDITS);
        end else if (accept && !credit_i) begin
            credits_q <= credits_q - 1'b1;
        end else if (!accept && credit_i && credits_q != CREDIT_W'(DEC_CREDITS)) begin
            credits_q <= credits_q + 1'b1;  // saturates at the buffer depth
        end
    end

    // ------------------------------------------------------------------------
    // output register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dec_valid_o <= 1'b0;
        end else begin
            dec_valid_o <= accept;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            dec_o <= dec_d;
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_rv_decode_stage.sv ====
// directed testbench for the RV32I decode stage against a reference model of the decode rules
`timescale 1ns/1ps
`default_nettype none

module tb_rv_decode_stage import rv_decode_pkg::*; ();

    localparam int CLK_PERIOD = 4;
    localparam int N_ALU      = 40;
    localparam int N_IMM      = 20;
    localparam int N_CSR      = 24;
    localparam int NUM_INS    = 2 * N_ALU + 6 * N_IMM + N_CSR + 60;

    logic             clk;
    logic             arst_n_i;
    logic             ins_valid_i;
    logic [INS_W-1:0] ins_i;
    logic             ins_ready_o;
    logic             dec_valid_o;
    dec_bundle_t      dec_o;
    logic             credit_i;

    rv_decode_stage u_dut (
        .clk_i       (clk),
        .arst_n_i    (arst_n_i),
        .ins_valid_i (ins_valid_i),
        .ins_i       (ins_i),
        .ins_ready_o (ins_ready_o),
        .dec_valid_o (dec_valid_o),
        .dec_o       (dec_o),
        .credit_i    (credit_i)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------------------------------------------------
    // failure handling and compare tasks
    // ------------------------------------------------------------------------
    task automatic end_with_failure();
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_alu_op(input string name, input alu_op_e got, input alu_op_e exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_zone(input string name, input zone_e got, input zone_e exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_imm(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_reg_addr(input string name, input logic [REG_ADDR_W-1:0] got,
                                  input logic [REG_ADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_csr_addr(input string name, input logic [CSR_ADDR_W-1:0] got,
                                  input logic [CSR_ADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            end_with_failure();
        end
    endtask

    // ------------------------------------------------------------------------
    // reference model of the op / op-imm rules
    // ------------------------------------------------------------------------
    function automatic alu_op_e ref_alu_op(input logic [2:0] f3, input logic [6:0] f7,
                                           input logic imm_form);
        alu_op_e op;
        case (f3)
            3'd0:    op = (!imm_form && f7 == F7_ALT) ? ALU_SUB : ALU_ADD;
            3'd1:    op = ALU_SLL;
            3'd2:    op = ALU_SLT;
            3'd3:    op = ALU_SLTU;
            3'd4:    op = ALU_XOR;
            3'd5:    op = (f7 == F7_ALT) ? ALU_SRA : ALU_SRL;
            3'd6:    op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    function automatic logic ref_alu_err(input logic [2:0] f3, input logic [6:0] f7,
                                         input logic imm_form);
        if (imm_form) begin
            if (f3 == 3'd1) return f7 != F7_BASE;   // slli
            if (f3 == 3'd5) return f7 != F7_BASE && f7 != F7_ALT;
            return 1'b0;
        end
        return !(f7 == F7_BASE || (f7 == F7_ALT && (f3 == 3'd0 || f3 == 3'd5)));
    endfunction

    // one instruction through the stage, slot handed back right after
    task automatic send(input logic [INS_W-1:0] ins, output dec_bundle_t got);
        ins_valid_i = 1'b1;
        ins_i       = ins;
        while (!ins_ready_o) @(negedge clk);
        @(negedge clk);  // accepted on the rising edge in between
        ins_valid_i = 1'b0;
        check_bit("dec_valid_o", dec_valid_o, 1'b1);
        got      = dec_o;
        credit_i = 1'b1;
        @(negedge clk);
        credit_i = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------------
    task automatic test_alu_ops();
        dec_bundle_t got;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic        form;
        int          pick;
        int          k;
        for (k = 0; k < 2 * N_ALU; k++) begin
            form = k[0];
            f3   = 3'($urandom);
            pick = $urandom % 3;
            f7   = (pick == 0) ? F7_BASE : (pick == 1) ? F7_ALT : 7'($urandom);
            rd   = 5'($urandom);
            rs1  = 5'($urandom);
            rs2  = 5'($urandom);
            send({f7, rs2, rs1, f3, rd, form ? OPC_OP_IMM : OPC_OP}, got);
            check_alu_op("aluop", got.aluop, ref_alu_op(f3, f7, form));
            check_bit("err", got.err, ref_alu_err(f3, f7, form));
            check_bit("selcmps2_imm", got.selcmps2_imm, form && (f3 == 3'd2 || f3 == 3'd3));
            check_bit("sels2_imm", got.sels2_imm, form);
            check_bit("regs2_rd", got.regs2_rd, !form);
            check_zone("zone", got.zone, ZONE_REGFILE);
            check_reg_addr("regd_addr", got.regd_addr, rd);
            check_reg_addr("regs1_addr", got.regs1_addr, rs1);
            check_reg_addr("regs2_addr", got.regs2_addr, rs2);
        end
    endtask

    task automatic test_immediates();
        dec_bundle_t      got;
        logic [INS_W-1:0] raw;
        logic [INS_W-1:0] ins;
        logic [XLEN-1:0]  exp;
        int               k;
        for (k = 0; k < 6 * N_IMM; k++) begin
            raw = $urandom;
            case (k % 6)
                0: begin
                    ins = {raw[31:15], 3'b000, raw[11:7], OPC_OP_IMM};
                    exp = {{20{raw[31]}}, raw[31:20]};
                end
                1: begin
                    ins = {raw[31:15], 3'b010, raw[11:7], OPC_STORE};
                    exp = {{20{raw[31]}}, raw[31:25], raw[11:7]};
                end
                2: begin
                    ins = {raw[31:15], 3'b000, raw[11:7], OPC_BRANCH};
                    exp = {{19{raw[31]}}, raw[31], raw[7], raw[30:25], raw[11:8], 1'b0};
                end
                3: begin
                    ins = {raw[31:7], OPC_LUI};
                    exp = {raw[31:12], 12'h000};
                end
                4: begin
                    ins = {raw[31:7], OPC_JAL};
                    exp = {{11{raw[31]}}, raw[31], raw[19:12], raw[20], raw[30:21], 1'b0};
                end
                default: begin  // csr zimm forms
                    ins = {raw[31:15], 3'(5 + $urandom % 3), raw[11:7], OPC_SYSTEM};
                    exp = {27'b0, raw[19:15]};
                end
            endcase
            send(ins, got);
            check_imm("imm", got.imm, exp);
            check_bit("err", got.err, 1'b0);
        end
    endtask

    task automatic test_mem_and_jumps();
        dec_bundle_t got;
        logic [2:0]  f3;
        int          k;
        for (k = 0; k < 8; k++) begin
            f3 = 3'(k);
            send({12'($urandom), 5'($urandom), f3, 5'($urandom), OPC_LOAD}, got);
            check_zone("zone", got.zone, ZONE_LOADQ);
            // lb lh lw lbu lhu
            check_bit("err", got.err, !(f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}));
            check_bit("regd_tgt", got.regd_tgt, 1'b1);
            check_bit("regs1_rd", got.regs1_rd, 1'b1);
            check_bit("jump", got.jump, 1'b0);

            send({12'($urandom), 5'($urandom), f3, 5'($urandom), OPC_STORE}, got);
            check_zone("zone", got.zone, ZONE_STOREQ);
            check_bit("err", got.err, !(f3 inside {3'd0, 3'd1, 3'd2}));  // sb sh sw
            check_bit("regd_tgt", got.regd_tgt, 1'b0);
            check_bit("regs2_rd", got.regs2_rd, 1'b1);

            send({12'($urandom), 5'($urandom), f3, 5'($urandom), OPC_BRANCH}, got);
            check_zone("zone", got.zone, ZONE_NONE);
            // beq bne blt bge bltu bgeu
            check_bit("err", got.err, !(f3 inside {3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7}));
            check_bit("jump", got.jump, 1'b1);
            check_bit("conditional", got.conditional, 1'b1);
            check_bit("link", got.link, 1'b0);
            check_bit("sels1_pc", got.sels1_pc, 1'b1);

            send({12'($urandom), 5'($urandom), f3, 5'($urandom), OPC_JALR}, got);
            check_zone("zone", got.zone, ZONE_REGFILE);
            check_bit("err", got.err, f3 != 3'd0);
            check_bit("link", got.link, 1'b1);
            check_bit("regs1_rd", got.regs1_rd, 1'b1);
            check_bit("conditional", got.conditional, 1'b0);
            check_bit("sels1_pc", got.sels1_pc, 1'b0);
        end
        send({25'($urandom), OPC_JAL}, got);
        check_bit("jump", got.jump, 1'b1);
        check_bit("link", got.link, 1'b1);
        check_bit("regs1_rd", got.regs1_rd, 1'b0);
        check_bit("sels1_pc", got.sels1_pc, 1'b1);
        check_bit("err", got.err, 1'b0);
    endtask

    task automatic test_system();
        dec_bundle_t      got;
        logic [6:0]       bad_opc [0:3];
        logic [4:0]       rd;
        logic [4:0]       rs1;
        logic [2:0]       f3;
        logic [11:0]      csr;
        int               k;
        bad_opc[0] = 7'b0000000;
        bad_opc[1] = 7'b1111111;
        bad_opc[2] = 7'b1010011;
        bad_opc[3] = 7'b0101111;
        send(32'h0000_0073, got);  // ecall
        check_bit("ecall", got.ecall, 1'b1);
        check_bit("err", got.err, 1'b0);
        send(32'h0010_0073, got);  // ebreak does nothing
        check_bit("ecall", got.ecall, 1'b0);
        check_bit("err", got.err, 1'b0);
        send(32'h1050_0073, got);
        check_bit("wfi", got.wfi, 1'b1);
        check_bit("err", got.err, 1'b0);
        send(32'h0000_100f, got);  // fence.i
        check_bit("fencei", got.fencei, 1'b1);
        check_bit("err", got.err, 1'b0);
        send(32'h0ff0_000f, got);  // fence
        check_bit("fencei", got.fencei, 1'b0);
        check_bit("err", got.err, 1'b0);
        for (k = 0; k < 4; k++) begin
            send({2'b00, 2'(k), F8_TRAP_RTN, 13'h0, OPC_SYSTEM}, got);
            check_bit("trap_rtn", got.trap_rtn, 1'b1);
            check_bit("trap_rtn_mode[1]", got.trap_rtn_mode[1], k[1]);
            check_bit("trap_rtn_mode[0]", got.trap_rtn_mode[0], k[0]);
            check_bit("err", got.err, 1'b0);
        end
        send({F7_SFENCE_VMA, 5'($urandom), 5'($urandom), F3_PRIV, 5'd0, OPC_SYSTEM}, got);
        check_bit("err", got.err, 1'b1);
        send({12'h000, 5'd0, F3_PRIV, 5'd1, OPC_SYSTEM}, got);  // ecall with rd set
        check_bit("err", got.err, 1'b1);
        send({12'($urandom), 5'($urandom), 3'b100, 5'($urandom), OPC_SYSTEM}, got);
        check_bit("err", got.err, 1'b1);
        for (k = 0; k < 4; k++) begin
            send({25'($urandom), bad_opc[k]}, got);
            check_bit("err", got.err, 1'b1);
        end
        for (k = 0; k < N_CSR; k++) begin
            f3  = {1'($urandom), 2'(1 + $urandom % 3)};
            rd  = ($urandom % 2) ? 5'($urandom % 31 + 1) : 5'd0;
            rs1 = ($urandom % 2) ? 5'($urandom % 31 + 1) : 5'd0;
            csr = 12'($urandom);
            send({csr, rs1, f3, rd, OPC_SYSTEM}, got);
            check_bit("csr_rd", got.csr_rd, rd != 5'd0);
            check_bit("csr_wr", got.csr_wr, rs1 != 5'd0);
            check_bit("sel_csr_wr_data_imm", got.sel_csr_wr_data_imm, f3[2]);
            check_bit("err", got.err, 1'b0);
            check_zone("zone", got.zone, ZONE_REGFILE);
            check_csr_addr("csr_addr", got.csr_addr, csr);
        end
    endtask

    // one cycle of the credit run against a model counter
    task automatic credit_step(input logic credit, inout int model, inout int accepts);
        logic acc;
        acc = ins_valid_i && (model > 0);
        check_bit("ins_ready_o", ins_ready_o, model > 0);
        credit_i = credit;
        @(negedge clk);
        check_bit("dec_valid_o", dec_valid_o, acc);
        if (acc && !credit)
            model--;
        else if (!acc && credit && model < DEC_CREDITS)
            model++;
        if (acc)
            accepts++;
    endtask

    task automatic test_credit_flow();
        int model;
        int accepts;
        model       = DEC_CREDITS;
        accepts     = 0;
        ins_valid_i = 1'b1;
        ins_i       = 32'h0010_0093;  // addi x1, x0, 1
        repeat (4) credit_step(1'b0, model, accepts);
        check_count("accepts", accepts, DEC_CREDITS);
        credit_step(1'b1, model, accepts);
        repeat (3) credit_step(1'b0, model, accepts);
        check_count("accepts", accepts, DEC_CREDITS + 1);
        // second credit lands together with an accept
        credit_step(1'b1, model, accepts);
        credit_step(1'b1, model, accepts);
        repeat (2) credit_step(1'b0, model, accepts);
        check_count("accepts", accepts, DEC_CREDITS + 3);
        ins_valid_i = 1'b0;
        repeat (DEC_CREDITS) credit_step(1'b1, model, accepts);
        credit_step(1'b1, model, accepts);  // extra credit while full is dropped
        ins_valid_i = 1'b1;
        repeat (DEC_CREDITS + 1) credit_step(1'b0, model, accepts);
        check_count("accepts", accepts, 2 * DEC_CREDITS + 3);
        ins_valid_i = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // main sequence and watchdog
    // ------------------------------------------------------------------------
    initial begin
        void'($urandom(32'h29bf_f43f));
        arst_n_i    = 1'b0;
        ins_valid_i = 1'b0;
        ins_i       = '0;
        credit_i    = 1'b0;
        repeat (2) @(negedge clk);
        arst_n_i = 1'b1;
        check_bit("ins_ready_o", ins_ready_o, 1'b1);
        check_bit("dec_valid_o", dec_valid_o, 1'b0);
        test_alu_ops();
        test_immediates();
        test_mem_and_jumps();
        test_system();
        test_credit_flow();
        $display("** PASS **");
        $finish;
    end

    initial begin
        #(NUM_INS * 20 * CLK_PERIOD + 100 * CLK_PERIOD);
        $display("timeout: the tests did not finish in the expected time");
        end_with_failure();
    end

endmodule

`default_nettype wire

// ==== list.f ====
hw/rv_decode_pkg.sv
hw/rv_alu_op_decode.sv
hw/rv_sys_decode.sv
hw/rv_imm_gen.sv
hw/rv_ctrl_decode.sv
hw/rv_decode_stage.sv
test/tb_rv_decode_stage.sv

// ==== run.sh ====
#!/bin/sh
# build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_rv_decode_stage -f list.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "\*\* FAIL \*\*" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "\*\* PASS \*\*" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
